//--- rtl/ex_pkg.sv
// shared widths, MIPS encodings and stage structs; 32-bit data only, no coprocessor or divide ops
package ex_pkg;

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 5;

  // ************************************************************************
  // MIPS opcode and funct encodings
  // ************************************************************************
  localparam logic [5:0] OPC_SPECIAL = 6'h00;
  localparam logic [5:0] OPC_ADDI    = 6'h08;
  localparam logic [5:0] OPC_ADDIU   = 6'h09;
  localparam logic [5:0] OPC_SLTI    = 6'h0a;
  localparam logic [5:0] OPC_SLTIU   = 6'h0b;
  localparam logic [5:0] OPC_ANDI    = 6'h0c;
  localparam logic [5:0] OPC_ORI     = 6'h0d;
  localparam logic [5:0] OPC_XORI    = 6'h0e;
  localparam logic [5:0] OPC_LUI     = 6'h0f;

  localparam logic [5:0] FN_SLL   = 6'h00;
  localparam logic [5:0] FN_SRL   = 6'h02;
  localparam logic [5:0] FN_SRA   = 6'h03;
  localparam logic [5:0] FN_SLLV  = 6'h04;
  localparam logic [5:0] FN_SRLV  = 6'h06;
  localparam logic [5:0] FN_SRAV  = 6'h07;
  localparam logic [5:0] FN_MFHI  = 6'h10;
  localparam logic [5:0] FN_MTHI  = 6'h11;
  localparam logic [5:0] FN_MFLO  = 6'h12;
  localparam logic [5:0] FN_MTLO  = 6'h13;
  localparam logic [5:0] FN_MULT  = 6'h18;
  localparam logic [5:0] FN_MULTU = 6'h19;
  localparam logic [5:0] FN_ADD   = 6'h20;
  localparam logic [5:0] FN_ADDU  = 6'h21;
  localparam logic [5:0] FN_SUB   = 6'h22;
  localparam logic [5:0] FN_SUBU  = 6'h23;
  localparam logic [5:0] FN_AND   = 6'h24;
  localparam logic [5:0] FN_OR    = 6'h25;
  localparam logic [5:0] FN_XOR   = 6'h26;
  localparam logic [5:0] FN_NOR   = 6'h27;
  localparam logic [5:0] FN_SLT   = 6'h2a;
  localparam logic [5:0] FN_SLTU  = 6'h2b;

  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [2*DATA_W-1:0]   dword_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // immediate forms share the register op, opb already holds the immediate
  typedef enum logic [4:0] {
    OP_NOP, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI,
    OP_SLL, OP_SRL, OP_SRA,
    OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
    OP_MULT, OP_MULTU, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO
  } alu_op_e;

  typedef enum logic [1:0] {RES_ALU, RES_HI, RES_LO, RES_NONE} res_sel_e;

  typedef struct packed {
    logic [5:0]         opcode;
    reg_addr_t          rs;
    reg_addr_t          rt;
    reg_addr_t          rd;
    logic [SHAMT_W-1:0] shamt;
    logic [5:0]         funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm16;
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } inst_u;

  typedef struct packed {
    alu_op_e            op;
    res_sel_e           sel;
    word_t              opa;
    word_t              opb;
    logic [SHAMT_W-1:0] shamt;
    reg_addr_t          waddr;
    logic               wreg;
  } ex_req_t;

  typedef struct packed {
    word_t     data;
    logic      ov;
    reg_addr_t waddr;
    logic      wreg;
    res_sel_e  sel;
  } alu_res_t;

  typedef struct packed {
    word_t     wdata;
    reg_addr_t waddr;
    logic      wreg;
    logic      ov;
  } wb_t;

endpackage

//--- rtl/ex_decode.sv
// decode stage; one request per in_valid_i strobe, unknown encodings pass as nop with wreg low
`timescale 1ns/1ns
module ex_decode
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            in_valid_i,
  input  ex_pkg::inst_u   inst_i,
  input  ex_pkg::word_t   reg1_i,
  input  ex_pkg::word_t   reg2_i,
  output ex_pkg::ex_req_t req_o,
  output logic            req_valid_o
);

  ex_pkg::ex_req_t req_d;
  ex_pkg::word_t   simm;
  ex_pkg::word_t   zimm;

  // immediate extensions
  assign simm = {{(ex_pkg::DATA_W-16){inst_i.i.imm16[15]}}, inst_i.i.imm16};
  assign zimm = {{(ex_pkg::DATA_W-16){1'b0}}, inst_i.i.imm16};

  // ************************************************************************
  // opcode / funct decode
  // ************************************************************************
  always_comb
  begin
    req_d.op    = ex_pkg::OP_NOP;
    req_d.sel   = ex_pkg::RES_ALU;
    req_d.opa   = reg1_i;
    req_d.opb   = reg2_i;
    req_d.shamt = inst_i.r.shamt;
    req_d.waddr = inst_i.r.rd;
    req_d.wreg  = 1'b1;
    if (inst_i.r.opcode == ex_pkg::OPC_SPECIAL)
    begin
      case (inst_i.r.funct)
        ex_pkg::FN_AND:   req_d.op = ex_pkg::OP_AND;
        ex_pkg::FN_OR:    req_d.op = ex_pkg::OP_OR;
        ex_pkg::FN_XOR:   req_d.op = ex_pkg::OP_XOR;
        ex_pkg::FN_NOR:   req_d.op = ex_pkg::OP_NOR;
        ex_pkg::FN_SLL:   req_d.op = ex_pkg::OP_SLL;
        ex_pkg::FN_SRL:   req_d.op = ex_pkg::OP_SRL;
        ex_pkg::FN_SRA:   req_d.op = ex_pkg::OP_SRA;
        ex_pkg::FN_ADD:   req_d.op = ex_pkg::OP_ADD;
        ex_pkg::FN_ADDU:  req_d.op = ex_pkg::OP_ADDU;
        ex_pkg::FN_SUB:   req_d.op = ex_pkg::OP_SUB;
        ex_pkg::FN_SUBU:  req_d.op = ex_pkg::OP_SUBU;
        ex_pkg::FN_SLT:   req_d.op = ex_pkg::OP_SLT;
        ex_pkg::FN_SLTU:  req_d.op = ex_pkg::OP_SLTU;
        ex_pkg::FN_MULT:  req_d.op = ex_pkg::OP_MULT;
        ex_pkg::FN_MULTU: req_d.op = ex_pkg::OP_MULTU;
        ex_pkg::FN_MTHI:  req_d.op = ex_pkg::OP_MTHI;
        ex_pkg::FN_MTLO:  req_d.op = ex_pkg::OP_MTLO;
        ex_pkg::FN_SLLV:
        begin
          req_d.op    = ex_pkg::OP_SLL;
          req_d.shamt = reg1_i[ex_pkg::SHAMT_W-1:0];
        end
        ex_pkg::FN_SRLV:
        begin
          req_d.op    = ex_pkg::OP_SRL;
          req_d.shamt = reg1_i[ex_pkg::SHAMT_W-1:0];
        end
        ex_pkg::FN_SRAV:
        begin
          req_d.op    = ex_pkg::OP_SRA;
          req_d.shamt = reg1_i[ex_pkg::SHAMT_W-1:0];
        end
        ex_pkg::FN_MFHI:
        begin
          req_d.op  = ex_pkg::OP_MFHI;
          req_d.sel = ex_pkg::RES_HI;
        end
        ex_pkg::FN_MFLO:
        begin
          req_d.op  = ex_pkg::OP_MFLO;
          req_d.sel = ex_pkg::RES_LO;
        end
        default:          req_d.op = ex_pkg::OP_NOP;
      endcase
    end
    else
    begin
      req_d.waddr = inst_i.i.rt;
      case (inst_i.i.opcode)
        ex_pkg::OPC_ADDI:
        begin
          req_d.op  = ex_pkg::OP_ADD;
          req_d.opb = simm;
        end
        ex_pkg::OPC_ADDIU:
        begin
          req_d.op  = ex_pkg::OP_ADDU;
          req_d.opb = simm;
        end
        ex_pkg::OPC_SLTI:
        begin
          req_d.op  = ex_pkg::OP_SLT;
          req_d.opb = simm;
        end
        // sltiu compares against the sign-extended immediate as unsigned
        ex_pkg::OPC_SLTIU:
        begin
          req_d.op  = ex_pkg::OP_SLTU;
          req_d.opb = simm;
        end
        ex_pkg::OPC_ANDI:
        begin
          req_d.op  = ex_pkg::OP_AND;
          req_d.opb = zimm;
        end
        ex_pkg::OPC_ORI:
        begin
          req_d.op  = ex_pkg::OP_OR;
          req_d.opb = zimm;
        end
        ex_pkg::OPC_XORI:
        begin
          req_d.op  = ex_pkg::OP_XOR;
          req_d.opb = zimm;
        end
        ex_pkg::OPC_LUI:
        begin
          req_d.op  = ex_pkg::OP_LUI;
          req_d.opb = {inst_i.i.imm16, {(ex_pkg::DATA_W-16){1'b0}}};
        end
        default:
          req_d.op = ex_pkg::OP_NOP;
      endcase
    end
    // no register write for hilo writers, unknown ops and $zero
    if ((req_d.op == ex_pkg::OP_NOP) || (req_d.op == ex_pkg::OP_MULT) ||
        (req_d.op == ex_pkg::OP_MULTU) || (req_d.op == ex_pkg::OP_MTHI) ||
        (req_d.op == ex_pkg::OP_MTLO))
    begin
      req_d.sel  = ex_pkg::RES_NONE;
      req_d.wreg = 1'b0;
    end
    if (req_d.waddr == '0)
      req_d.wreg = 1'b0;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      req_valid_o <= 1'b0;
    else
      req_valid_o <= in_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (in_valid_i)
      req_o <= req_d;
  end

endmodule

//--- rtl/ex_alu.sv
// execute stage; single shared adder, overflow flagged only for add, addi and sub
`timescale 1ns/1ns
module ex_alu
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  ex_pkg::ex_req_t  req_i,
  input  logic             req_valid_i,
  output ex_pkg::alu_res_t res_o,
  output logic             res_valid_o
);

  logic          sub_en;
  ex_pkg::word_t opb_x;
  ex_pkg::word_t sum;
  logic          ov_sum;
  logic          lt_signed;
  logic          lt_unsigned;
  ex_pkg::word_t data_d;
  logic          ov_d;

  // ************************************************************************
  // adder, compare and overflow
  // ************************************************************************
  assign sub_en = (req_i.op == ex_pkg::OP_SUB) || (req_i.op == ex_pkg::OP_SUBU) ||
                  (req_i.op == ex_pkg::OP_SLT);

  // a - b as a + ~b + 1
  assign opb_x = sub_en ? ~req_i.opb : req_i.opb;
  assign sum   = req_i.opa + opb_x + {{(ex_pkg::DATA_W-1){1'b0}}, sub_en};

  assign ov_sum = (req_i.opa[ex_pkg::DATA_W-1] == opb_x[ex_pkg::DATA_W-1]) &&
                  (sum[ex_pkg::DATA_W-1] != req_i.opa[ex_pkg::DATA_W-1]);

  // unlike signs decide directly, like signs cannot overflow
  assign lt_signed = (req_i.opa[ex_pkg::DATA_W-1] && !req_i.opb[ex_pkg::DATA_W-1]) ||
                     ((req_i.opa[ex_pkg::DATA_W-1] == req_i.opb[ex_pkg::DATA_W-1]) &&
                      sum[ex_pkg::DATA_W-1]);
  assign lt_unsigned = req_i.opa < req_i.opb;

  assign ov_d = ((req_i.op == ex_pkg::OP_ADD) || (req_i.op == ex_pkg::OP_SUB)) && ov_sum;

  // ************************************************************************
  // result mux
  // ************************************************************************
  always_comb
  begin
    case (req_i.op)
      ex_pkg::OP_AND:  data_d = req_i.opa & req_i.opb;
      ex_pkg::OP_OR:   data_d = req_i.opa | req_i.opb;
      ex_pkg::OP_XOR:  data_d = req_i.opa ^ req_i.opb;
      ex_pkg::OP_NOR:  data_d = ~(req_i.opa | req_i.opb);
      ex_pkg::OP_LUI:  data_d = req_i.opb;
      ex_pkg::OP_SLL:  data_d = req_i.opb << req_i.shamt;
      ex_pkg::OP_SRL:  data_d = req_i.opb >> req_i.shamt;
      // sign fill
      ex_pkg::OP_SRA:  data_d = $signed(req_i.opb) >>> req_i.shamt;
      ex_pkg::OP_ADD,
      ex_pkg::OP_ADDU,
      ex_pkg::OP_SUB,
      ex_pkg::OP_SUBU: data_d = sum;
      ex_pkg::OP_SLT:  data_d = {{(ex_pkg::DATA_W-1){1'b0}}, lt_signed};
      ex_pkg::OP_SLTU: data_d = {{(ex_pkg::DATA_W-1){1'b0}}, lt_unsigned};
      default:         data_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      res_valid_o <= 1'b0;
    else
      res_valid_o <= req_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (req_valid_i)
    begin
      res_o.data  <= data_d;
      res_o.ov    <= ov_d;
      res_o.waddr <= req_i.waddr;
      res_o.wreg  <= req_i.wreg;
      res_o.sel   <= req_i.sel;
    end
  end

endmodule

//--- rtl/ex_hilo.sv
// HI/LO state; written in the execute cycle so a following mfhi/mflo needs no forwarding
`timescale 1ns/1ns
module ex_hilo
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  ex_pkg::ex_req_t req_i,
  input  logic            req_valid_i,
  output ex_pkg::word_t   hi_o,
  output ex_pkg::word_t   lo_o
);

  logic           mul_signed;
  ex_pkg::word_t  mag_a;
  ex_pkg::word_t  mag_b;
  ex_pkg::dword_t prod_mag;
  ex_pkg::dword_t product;

  // ************************************************************************
  // multiplier on magnitudes, sign restored afterwards
  // ************************************************************************
  assign mul_signed = (req_i.op == ex_pkg::OP_MULT);

  assign mag_a = (mul_signed && req_i.opa[ex_pkg::DATA_W-1]) ? -req_i.opa : req_i.opa;
  assign mag_b = (mul_signed && req_i.opb[ex_pkg::DATA_W-1]) ? -req_i.opb : req_i.opb;

  assign prod_mag = {{ex_pkg::DATA_W{1'b0}}, mag_a} * {{ex_pkg::DATA_W{1'b0}}, mag_b};

  assign product = (mul_signed &&
                    (req_i.opa[ex_pkg::DATA_W-1] ^ req_i.opb[ex_pkg::DATA_W-1])) ?
                   -prod_mag : prod_mag;

  // architectural registers, cleared on reset
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      hi_o <= '0;
      lo_o <= '0;
    end
    else if (req_valid_i)
    begin
      case (req_i.op)
        ex_pkg::OP_MULT,
        ex_pkg::OP_MULTU:
        begin
          hi_o <= product[2*ex_pkg::DATA_W-1:ex_pkg::DATA_W];
          lo_o <= product[ex_pkg::DATA_W-1:0];
        end
        ex_pkg::OP_MTHI: hi_o <= req_i.opa;
        ex_pkg::OP_MTLO: lo_o <= req_i.opa;
        default:
        begin
          hi_o <= hi_o;
          lo_o <= lo_o;
        end
      endcase
    end
  end

endmodule

//--- rtl/ex_result.sv
// write-back stage; hi_i/lo_i are sampled here, which holds only while order is kept per stage
`timescale 1ns/1ns
module ex_result
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  ex_pkg::alu_res_t res_i,
  input  logic             res_valid_i,
  input  ex_pkg::word_t    hi_i,
  input  ex_pkg::word_t    lo_i,
  output ex_pkg::wb_t      wb_o,
  output logic             valid_o
);

  ex_pkg::wb_t wb_d;

  always_comb
  begin
    case (res_i.sel)
      ex_pkg::RES_ALU: wb_d.wdata = res_i.data;
      ex_pkg::RES_HI:  wb_d.wdata = hi_i;
      ex_pkg::RES_LO:  wb_d.wdata = lo_i;
      default:         wb_d.wdata = '0;
    endcase
    wb_d.waddr = res_i.waddr;
    wb_d.ov    = res_i.ov;
    // overflow kills the register write
    wb_d.wreg  = res_i.wreg && !res_i.ov;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      valid_o <= 1'b0;
      wb_o    <= '0;
    end
    else
    begin
      valid_o <= res_valid_i;
      if (res_valid_i)
        wb_o <= wb_d;
    end
  end

endmodule

//--- rtl/ex_top.sv
// execute unit top; three register stages, a strobe every cycle allowed, no back-pressure
`timescale 1ns/1ns
module ex_top
(
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          in_valid_i,
  input  ex_pkg::inst_u inst_i,
  input  ex_pkg::word_t reg1_i,
  input  ex_pkg::word_t reg2_i,
  output ex_pkg::wb_t   wb_o,
  output logic          valid_o
);

  ex_pkg::ex_req_t  req;
  logic             req_valid;
  ex_pkg::alu_res_t alu_res;
  logic             alu_res_valid;
  ex_pkg::word_t    hi;
  ex_pkg::word_t    lo;

  // ************************************************************************
  // decode -> execute (alu + hilo) -> write-back
  // ************************************************************************
  ex_decode i_ex_decode
  (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .inst_i      (inst_i),
    .reg1_i      (reg1_i),
    .reg2_i      (reg2_i),
    .req_o       (req),
    .req_valid_o (req_valid)
  );

  ex_alu i_ex_alu
  (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req),
    .req_valid_i (req_valid),
    .res_o       (alu_res),
    .res_valid_o (alu_res_valid)
  );

  ex_hilo i_ex_hilo
  (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req),
    .req_valid_i (req_valid),
    .hi_o        (hi),
    .lo_o        (lo)
  );

  ex_result i_ex_result
  (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .res_i       (alu_res),
    .res_valid_i (alu_res_valid),
    .hi_i        (hi),
    .lo_i        (lo),
    .wb_o        (wb_o),
    .valid_o     (valid_o)
  );

endmodule

//--- test/tb_ex_model.svh
// reference model of the execute unit; its HI/LO copy advances per call, so call once per issue
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// model copy of the architectural HI/LO pair
ex_pkg::word_t model_hi = '0;
ex_pkg::word_t model_lo = '0;

function automatic ex_pkg::wb_t predict_wb(input ex_pkg::inst_u inst, input ex_pkg::word_t a,
                                           input ex_pkg::word_t b);
  ex_pkg::wb_t    wb;
  ex_pkg::word_t  simm;
  ex_pkg::word_t  zimm;
  logic [32:0]    wide;
  ex_pkg::dword_t prod;
  logic           known;
  logic           no_write;
  wb       = '0;
  known    = 1'b1;
  no_write = 1'b0;
  simm     = {{16{inst.i.imm16[15]}}, inst.i.imm16};
  zimm     = {16'h0000, inst.i.imm16};
  if (inst.r.opcode == ex_pkg::OPC_SPECIAL)
  begin
    wb.waddr = inst.r.rd;
    case (inst.r.funct)
      ex_pkg::FN_AND:  wb.wdata = a & b;
      ex_pkg::FN_OR:   wb.wdata = a | b;
      ex_pkg::FN_XOR:  wb.wdata = a ^ b;
      ex_pkg::FN_NOR:  wb.wdata = ~(a | b);
      ex_pkg::FN_SLL:  wb.wdata = b << inst.r.shamt;
      ex_pkg::FN_SRL:  wb.wdata = b >> inst.r.shamt;
      ex_pkg::FN_SRA:  wb.wdata = $signed(b) >>> inst.r.shamt;
      ex_pkg::FN_SLLV: wb.wdata = b << a[4:0];
      ex_pkg::FN_SRLV: wb.wdata = b >> a[4:0];
      ex_pkg::FN_SRAV: wb.wdata = $signed(b) >>> a[4:0];
      // 33-bit sums, overflow when the two top bits disagree
      ex_pkg::FN_ADD,
      ex_pkg::FN_ADDU:
      begin
        wide     = {a[31], a} + {b[31], b};
        wb.wdata = wide[31:0];
        wb.ov    = (inst.r.funct == ex_pkg::FN_ADD) && (wide[32] != wide[31]);
      end
      ex_pkg::FN_SUB,
      ex_pkg::FN_SUBU:
      begin
        wide     = {a[31], a} - {b[31], b};
        wb.wdata = wide[31:0];
        wb.ov    = (inst.r.funct == ex_pkg::FN_SUB) && (wide[32] != wide[31]);
      end
      ex_pkg::FN_SLT:  wb.wdata = {31'd0, $signed(a) < $signed(b)};
      ex_pkg::FN_SLTU: wb.wdata = {31'd0, a < b};
      ex_pkg::FN_MULT:
      begin
        prod     = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        model_hi = prod[63:32];
        model_lo = prod[31:0];
        no_write = 1'b1;
      end
      ex_pkg::FN_MULTU:
      begin
        prod     = {32'd0, a} * {32'd0, b};
        model_hi = prod[63:32];
        model_lo = prod[31:0];
        no_write = 1'b1;
      end
      ex_pkg::FN_MFHI: wb.wdata = model_hi;
      ex_pkg::FN_MFLO: wb.wdata = model_lo;
      ex_pkg::FN_MTHI:
      begin
        model_hi = a;
        no_write = 1'b1;
      end
      ex_pkg::FN_MTLO:
      begin
        model_lo = a;
        no_write = 1'b1;
      end
      default:         known = 1'b0;
    endcase
  end
  else
  begin
    wb.waddr = inst.i.rt;
    case (inst.i.opcode)
      ex_pkg::OPC_ADDI:
      begin
        wide     = {a[31], a} + {simm[31], simm};
        wb.wdata = wide[31:0];
        wb.ov    = wide[32] != wide[31];
      end
      ex_pkg::OPC_ADDIU: wb.wdata = a + simm;
      ex_pkg::OPC_SLTI:  wb.wdata = {31'd0, $signed(a) < $signed(simm)};
      ex_pkg::OPC_SLTIU: wb.wdata = {31'd0, a < simm};
      ex_pkg::OPC_ANDI:  wb.wdata = a & zimm;
      ex_pkg::OPC_ORI:   wb.wdata = a | zimm;
      ex_pkg::OPC_XORI:  wb.wdata = a ^ zimm;
      ex_pkg::OPC_LUI:   wb.wdata = {inst.i.imm16, 16'h0000};
      default:           known = 1'b0;
    endcase
  end
  // $zero, HI/LO writers, unknown words and overflow write nothing
  wb.wreg = known && !no_write && (wb.waddr != 5'd0) && !wb.ov;
  return wb;
endfunction

`endif

//--- test/tb_ex_top.sv
// self-checking testbench for ex_top; expects 3-cycle latency, fixed seed, stops at first error
`timescale 1ns/1ns
module tb_ex_top;

  typedef struct packed {
    ex_pkg::inst_u inst;
    ex_pkg::word_t opa;
    ex_pkg::word_t opb;
  } stim_t;

  logic          clk_i;
  logic          arst_n_i;
  logic          in_valid_i;
  ex_pkg::inst_u inst_i;
  ex_pkg::word_t reg1_i;
  ex_pkg::word_t reg2_i;
  ex_pkg::wb_t   wb_o;
  logic          valid_o;

  integer        seed;
  int            cycles = 0;
  int            cycle_limit;
  stim_t         prog_q [$];
  ex_pkg::wb_t   expect_q [$];
  int            strobe_q [$];

  // encodings the random stream draws from
  logic [5:0] r_functs [$] = '{ex_pkg::FN_AND, ex_pkg::FN_OR, ex_pkg::FN_XOR, ex_pkg::FN_NOR,
    ex_pkg::FN_SLL, ex_pkg::FN_SRL, ex_pkg::FN_SRA, ex_pkg::FN_SLLV, ex_pkg::FN_SRLV,
    ex_pkg::FN_SRAV, ex_pkg::FN_ADD, ex_pkg::FN_ADDU, ex_pkg::FN_SUB, ex_pkg::FN_SUBU,
    ex_pkg::FN_SLT, ex_pkg::FN_SLTU, ex_pkg::FN_MULT, ex_pkg::FN_MULTU, ex_pkg::FN_MFHI,
    ex_pkg::FN_MFLO, ex_pkg::FN_MTHI, ex_pkg::FN_MTLO};
  logic [5:0] i_opcodes [$] = '{ex_pkg::OPC_ADDI, ex_pkg::OPC_ADDIU, ex_pkg::OPC_SLTI,
    ex_pkg::OPC_SLTIU, ex_pkg::OPC_ANDI, ex_pkg::OPC_ORI, ex_pkg::OPC_XORI, ex_pkg::OPC_LUI};

  `include "tb_ex_model.svh"

  ex_top i_ex_top
  (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_valid_i (in_valid_i),
    .inst_i     (inst_i),
    .reg1_i     (reg1_i),
    .reg2_i     (reg2_i),
    .wb_o       (wb_o),
    .valid_o    (valid_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  // ************************************************************************
  // compare tasks
  // ************************************************************************
  task automatic check_wb(input ex_pkg::wb_t got, input ex_pkg::wb_t exp);
    if (got !== exp)
    begin
      if (got.wdata !== exp.wdata)
        $display("[ERROR] %0t: wdata is %h, expected %h", $time, got.wdata, exp.wdata);
      if (got.waddr !== exp.waddr)
        $display("[ERROR] %0t: waddr is %0d, expected %0d", $time, got.waddr, exp.waddr);
      if (got.wreg !== exp.wreg)
        $display("[ERROR] %0t: wreg is %b, expected %b", $time, got.wreg, exp.wreg);
      if (got.ov !== exp.ov)
        $display("[ERROR] %0t: ov is %b, expected %b", $time, got.ov, exp.ov);
      abort_run();
    end
  endtask

  task automatic check_latency(input int issued, input int now);
    if ((now - issued) != 3)
    begin
      $display("[ERROR] %0t: valid_o %0d cycles after strobe, expected 3", $time, now - issued);
      abort_run();
    end
  endtask

  // ************************************************************************
  // stimulus builders
  // ************************************************************************
  function automatic ex_pkg::inst_u rtype_word(input logic [5:0] funct,
                                               input ex_pkg::reg_addr_t rd,
                                               input logic [4:0] shamt);
    ex_pkg::inst_u inst;
    inst.r = '{ex_pkg::OPC_SPECIAL, 5'd1, 5'd2, rd, shamt, funct};
    return inst;
  endfunction

  function automatic ex_pkg::inst_u itype_word(input logic [5:0] opcode,
                                               input ex_pkg::reg_addr_t rt,
                                               input logic [15:0] imm);
    ex_pkg::inst_u inst;
    inst.i = '{opcode, 5'd1, rt, imm};
    return inst;
  endfunction

  task automatic add_stim(input ex_pkg::inst_u inst, input ex_pkg::word_t a,
                          input ex_pkg::word_t b);
    stim_t s;
    s.inst = inst;
    s.opa  = a;
    s.opb  = b;
    prog_q.push_back(s);
  endtask

  task automatic add_directed();
    // HI still holds its reset value
    add_stim(rtype_word(ex_pkg::FN_MFHI, 5'd2, 5'd0), 32'h0, 32'h0);
    // overflow on the trapping forms, wrap on the others
    add_stim(rtype_word(ex_pkg::FN_ADD, 5'd3, 5'd0), 32'h7fff_ffff, 32'h0000_0001);
    add_stim(rtype_word(ex_pkg::FN_ADDU, 5'd3, 5'd0), 32'h7fff_ffff, 32'h0000_0001);
    add_stim(itype_word(ex_pkg::OPC_ADDI, 5'd4, 16'h0001), 32'h7fff_ffff, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_SUB, 5'd5, 5'd0), 32'h8000_0000, 32'h0000_0001);
    add_stim(rtype_word(ex_pkg::FN_SUBU, 5'd5, 5'd0), 32'h8000_0000, 32'h0000_0001);
    // mixed-sign compares
    add_stim(rtype_word(ex_pkg::FN_SLT, 5'd6, 5'd0), 32'hffff_ffff, 32'h0000_0001);
    add_stim(rtype_word(ex_pkg::FN_SLTU, 5'd6, 5'd0), 32'hffff_ffff, 32'h0000_0001);
    add_stim(itype_word(ex_pkg::OPC_SLTI, 5'd7, 16'h0005), 32'hffff_fff0, 32'h0);
    add_stim(itype_word(ex_pkg::OPC_SLTIU, 5'd7, 16'hffff), 32'h0000_0005, 32'h0);
    // sign fill, and a shift into $zero
    add_stim(rtype_word(ex_pkg::FN_SRA, 5'd8, 5'd4), 32'h0, 32'h8000_0010);
    add_stim(rtype_word(ex_pkg::FN_SRAV, 5'd8, 5'd0), 32'h0000_0024, 32'hf000_0000);
    add_stim(rtype_word(ex_pkg::FN_SLL, 5'd0, 5'd31), 32'h0, 32'h0000_0001);
    // multiply then read both halves right away
    add_stim(rtype_word(ex_pkg::FN_MULT, 5'd0, 5'd0), 32'hffff_fffe, 32'h0000_0003);
    add_stim(rtype_word(ex_pkg::FN_MFHI, 5'd9, 5'd0), 32'h0, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_MFLO, 5'd10, 5'd0), 32'h0, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_MULTU, 5'd0, 5'd0), 32'hffff_fffe, 32'h0000_0003);
    add_stim(rtype_word(ex_pkg::FN_MFHI, 5'd9, 5'd0), 32'h0, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_MFLO, 5'd10, 5'd0), 32'h0, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_MTHI, 5'd0, 5'd0), 32'h1234_5678, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_MFHI, 5'd11, 5'd0), 32'h0, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_MFLO, 5'd12, 5'd0), 32'h0, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_MTLO, 5'd0, 5'd0), 32'h9abc_def0, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_MFLO, 5'd12, 5'd0), 32'h0, 32'h0);
    add_stim(rtype_word(ex_pkg::FN_MFHI, 5'd11, 5'd0), 32'h0, 32'h0);
    // unknown funct and unknown opcode
    add_stim(rtype_word(6'h3f, 5'd13, 5'd0), 32'h1111_1111, 32'h2222_2222);
    add_stim(itype_word(6'h3f, 5'd14, 16'h1234), 32'h1111_1111, 32'h2222_2222);
  endtask

  task automatic add_random(input int count);
    stim_t s;
    int    pick;
    repeat (count)
    begin
      s.inst = $random(seed);
      s.opa  = $random(seed);
      s.opb  = $random(seed);
      pick   = $unsigned($random(seed)) % 31;
      if (pick < 22)
      begin
        s.inst.r.opcode = ex_pkg::OPC_SPECIAL;
        s.inst.r.funct  = r_functs[pick];
      end
      else if (pick < 30)
        s.inst.i.opcode = i_opcodes[pick - 22];
      else if (s.opa[0])
      begin
        s.inst.r.opcode = ex_pkg::OPC_SPECIAL;
        s.inst.r.funct  = 6'h3f;
      end
      else
        s.inst.i.opcode = 6'h3f;
      prog_q.push_back(s);
    end
  endtask

  task automatic issue(input stim_t s);
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    inst_i     <= s.inst;
    reg1_i     <= s.opa;
    reg2_i     <= s.opb;
    expect_q.push_back(predict_wb(s.inst, s.opa, s.opb));
  endtask

  // ************************************************************************
  // compare process on the falling edge
  // ************************************************************************
  always @(negedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (in_valid_i)
        strobe_q.push_back(cycles);
      if (valid_o)
      begin
        if (expect_q.size() == 0)
        begin
          $display("valid_o was asserted with no instruction outstanding");
          abort_run();
        end
        else
        begin
          check_latency(strobe_q.pop_front(), cycles);
          check_wb(wb_o, expect_q.pop_front());
        end
      end
    end
  end

  // timeout
  always @(posedge clk_i)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  initial
  begin
    seed = 32'h4fcd_2668;
    clk_i = 1'b0;
    arst_n_i   <= 1'b1;
    in_valid_i <= 1'b0;
    inst_i     <= '0;
    reg1_i     <= '0;
    reg2_i     <= '0;
    add_directed();
    add_random(400);
    cycle_limit = prog_q.size() + 5 + 20;
    // a real falling edge on the async reset
    #5;
    arst_n_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // idle cycles with no strobe
    repeat (3) @(posedge clk_i);
    foreach (prog_q[k])
      issue(prog_q[k]);
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    // last result is due three cycles after the final strobe
    repeat (5) @(negedge clk_i);
    if ((expect_q.size() != 0) || (strobe_q.size() != 0))
    begin
      $display("results still outstanding at the end of the run");
      abort_run();
    end
    else
    begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- sources.f
+incdir+test
rtl/ex_pkg.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_hilo.sv
rtl/ex_result.sv
rtl/ex_top.sv
test/tb_ex_top.sv

//--- Makefile
# Verilator flow for the execute unit testbench

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_ex_top -f sources.f

sim:
	verilator --binary --timing --top-module tb_ex_top -f sources.f \
		-Mdir $(OBJ_DIR) -o tb_ex_top
	./$(OBJ_DIR)/tb_ex_top | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
